/* verilog/fuse_lc_cfg.svh */
// Fuse array geometry, local reset length and fixed addresses, included by the RTL and testbench
`ifndef FUSE_LC_CFG_SVH
`define FUSE_LC_CFG_SVH

// Array geometry
`define FUSE_PART_NUM     8
`define FUSE_PART_WORDS   8
`define FUSE_WORD_NUM     (`FUSE_PART_NUM * `FUSE_PART_WORDS)
`define FUSE_ADDR_W       6
`define FUSE_WORD_IDX_W   3

// Word 7 of every partition holds the digest, nonzero means locked
`define FUSE_DIGEST_WORD  (`FUSE_PART_WORDS - 1)

// Length of the local reset pulse in clock cycles
`define SVC_RST_CYCLES    10

// Lifecycle word sits in word 0 of partition 6
`define LC_WORD_ADDR      48

`endif

/* verilog/fuse_lc_pkg.sv */
// Shared types of the fuse and lifecycle subsystem, referenced by scoped name from each block
`default_nettype none

package fuse_lc_pkg;

  // ----------------------------------------
  // Fuse word
  // ----------------------------------------

  // A fuse word is stored raw but checked as a data half against its mirror
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [15:0] mirror;
      logic [15:0] data;
    } half;
  } fuse_word_u;

  // ----------------------------------------
  // Service commands and override states
  // ----------------------------------------

  typedef enum logic [7:0] {
    CMD_FAULT_SOFT       = 8'h01,
    CMD_FAULT_HARD       = 8'h02,
    CMD_FAULT_RELEASE    = 8'h03,
    CMD_LOCAL_RESET      = 8'h10,
    CMD_ESCALATE         = 8'h20,
    CMD_ESCALATE_RELEASE = 8'h21,
    CMD_ZEROIZE          = 8'h30,
    CMD_ZEROIZE_RELEASE  = 8'h31,
    CMD_CLK_160          = 8'h40,
    CMD_CLK_400          = 8'h41,
    CMD_CLK_500          = 8'h42,
    CMD_CLK_1000         = 8'h43
  } svc_cmd_e;

  typedef enum logic [1:0] {
    FAULT_NONE = 2'd0,
    FAULT_SOFT = 2'd1,
    FAULT_HARD = 2'd2
  } fault_mode_e;

  // External clock choice in MHz
  typedef enum logic [1:0] {
    CLK_SEL_160  = 2'd0,
    CLK_SEL_400  = 2'd1,
    CLK_SEL_500  = 2'd2,
    CLK_SEL_1000 = 2'd3
  } clk_sel_e;

  typedef enum logic [2:0] {
    LC_RAW   = 3'd0,
    LC_TEST  = 3'd1,
    LC_DEV   = 3'd2,
    LC_PROD  = 3'd3,
    LC_SCRAP = 3'd4
  } lc_state_e;

endpackage

`default_nettype wire

/* verilog/fuse_svc_ctrl.sv */
// Service command decoder driving fault, escalation, zeroization, clock and local reset overrides
`timescale 1ns/1ps
`default_nettype none

`include "fuse_lc_cfg.svh"

module fuse_svc_ctrl (
  input  wire logic                   clk,
  input  wire logic                   cptra_rst_b,
  input  wire logic                   cmd_valid_i,
  input  wire fuse_lc_pkg::svc_cmd_e  cmd_i,
  output logic                        cmd_ready_o,
  input  wire logic                   clk_byp_ack_i,
  output fuse_lc_pkg::fault_mode_e    fault_mode_o,
  output logic                        escalate_o,
  output logic                        zeroize_req_o,
  output logic                        svc_rst_o,
  output fuse_lc_pkg::clk_sel_e       clk_sel_o,
  output logic                        clk_byp_req_o
);

  localparam logic [3:0] rst_last = 4'(`SVC_RST_CYCLES - 1);

  logic                  cmd_fire;
  logic                  rst_active_q;
  logic [3:0]            rst_cnt_q;
  logic                  clk_req_q;
  logic                  clk_cmd_hit;
  fuse_lc_pkg::clk_sel_e clk_cmd_sel;

  // No new command while the reset pulse runs or a clock switch is pending
  assign cmd_ready_o   = ~rst_active_q & ~clk_req_q;
  assign cmd_fire      = cmd_valid_i & cmd_ready_o;
  assign svc_rst_o     = rst_active_q;
  assign clk_byp_req_o = clk_req_q;

  // ----------------------------------------
  // Sticky overrides
  // ----------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      fault_mode_o  <= fuse_lc_pkg::FAULT_NONE;
      escalate_o    <= 1'b0;
      zeroize_req_o <= 1'b0;
    end else if (cmd_fire) begin
      case (cmd_i)
        // A fault is injected once and must be released before the next one
        fuse_lc_pkg::CMD_FAULT_SOFT: begin
          if (fault_mode_o == fuse_lc_pkg::FAULT_NONE) begin
            fault_mode_o <= fuse_lc_pkg::FAULT_SOFT;
          end
        end
        fuse_lc_pkg::CMD_FAULT_HARD: begin
          if (fault_mode_o == fuse_lc_pkg::FAULT_NONE) begin
            fault_mode_o <= fuse_lc_pkg::FAULT_HARD;
          end
        end
        fuse_lc_pkg::CMD_FAULT_RELEASE:    fault_mode_o  <= fuse_lc_pkg::FAULT_NONE;
        fuse_lc_pkg::CMD_ESCALATE:         escalate_o    <= 1'b1;
        fuse_lc_pkg::CMD_ESCALATE_RELEASE: escalate_o    <= 1'b0;
        fuse_lc_pkg::CMD_ZEROIZE:          zeroize_req_o <= 1'b1;
        fuse_lc_pkg::CMD_ZEROIZE_RELEASE:  zeroize_req_o <= 1'b0;
        default: begin
          // Other codes are handled below or dropped
        end
      endcase
    end
  end

  // ----------------------------------------
  // External clock request
  // ----------------------------------------
  always_comb begin
    clk_cmd_hit = 1'b1;
    clk_cmd_sel = fuse_lc_pkg::CLK_SEL_1000;
    case (cmd_i)
      fuse_lc_pkg::CMD_CLK_160:  clk_cmd_sel = fuse_lc_pkg::CLK_SEL_160;
      fuse_lc_pkg::CMD_CLK_400:  clk_cmd_sel = fuse_lc_pkg::CLK_SEL_400;
      fuse_lc_pkg::CMD_CLK_500:  clk_cmd_sel = fuse_lc_pkg::CLK_SEL_500;
      fuse_lc_pkg::CMD_CLK_1000: clk_cmd_sel = fuse_lc_pkg::CLK_SEL_1000;
      default:                   clk_cmd_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      clk_sel_o <= fuse_lc_pkg::CLK_SEL_1000;
      clk_req_q <= 1'b0;
    end else if (cmd_fire && clk_cmd_hit) begin
      clk_sel_o <= clk_cmd_sel;
      clk_req_q <= 1'b1;
    end else if (clk_req_q && clk_byp_ack_i) begin
      clk_req_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // Local reset pulse
  // ----------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rst_active_q <= 1'b0;
      rst_cnt_q    <= '0;
    end else if (cmd_fire && cmd_i == fuse_lc_pkg::CMD_LOCAL_RESET) begin
      rst_active_q <= 1'b1;
      rst_cnt_q    <= '0;
    end else if (rst_active_q) begin
      if (rst_cnt_q == rst_last) begin
        rst_active_q <= 1'b0;
        rst_cnt_q    <= '0;
      end else begin
        rst_cnt_q <= rst_cnt_q + 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/otp_fuse_array.sv */
// One-time-programmable fuse storage with lock checks, fault overlay and two read ports
`timescale 1ns/1ps
`default_nettype none

`include "fuse_lc_cfg.svh"

module otp_fuse_array (
  input  wire logic                     clk,
  input  wire logic                     cptra_rst_b,
  input  wire logic                     prog_valid_i,
  input  wire logic [`FUSE_ADDR_W-1:0]  prog_addr_i,
  input  wire logic [31:0]              prog_data_i,
  output logic                          prog_ready_o,
  output logic                          prog_err_o,
  input  wire fuse_lc_pkg::fault_mode_e fault_mode_i,
  input  wire logic [`FUSE_ADDR_W-1:0]  scan_addr_i,
  output fuse_lc_pkg::fuse_word_u       scan_word_o,
  output logic [15:0]                   lc_word_o
);

  localparam logic [`FUSE_ADDR_W-1:0] lc_addr = `FUSE_ADDR_W'(`LC_WORD_ADDR);

  fuse_lc_pkg::fuse_word_u   mem_q [`FUSE_WORD_NUM];
  fuse_lc_pkg::fuse_word_u   lc_word;
  logic [`FUSE_PART_NUM-1:0] locked;
  logic                      prog_fire;
  logic                      prog_locked;

  // Fault shows only on word 0 of a locked partition
  function automatic fuse_lc_pkg::fuse_word_u fault_overlay(
    input fuse_lc_pkg::fuse_word_u   word,
    input logic [`FUSE_ADDR_W-1:0]   addr,
    input logic [`FUSE_PART_NUM-1:0] lock,
    input fuse_lc_pkg::fault_mode_e  mode
  );
    fuse_lc_pkg::fuse_word_u res;
    logic                    hit;
    res = word;
    hit = (addr[`FUSE_WORD_IDX_W-1:0] == '0) &&
          lock[addr[`FUSE_ADDR_W-1:`FUSE_WORD_IDX_W]];
    if (hit && mode == fuse_lc_pkg::FAULT_SOFT) begin
      res.half.data[0] = ~word.half.data[0];
    end else if (hit && mode == fuse_lc_pkg::FAULT_HARD) begin
      res.half.data = ~word.half.data;
    end
    return res;
  endfunction

  always_comb begin
    for (int p = 0; p < `FUSE_PART_NUM; p++) begin
      locked[p] = |mem_q[p * `FUSE_PART_WORDS + `FUSE_DIGEST_WORD].raw;
    end
  end

  assign prog_fire   = prog_valid_i & prog_ready_o;
  assign prog_locked = locked[prog_addr_i[`FUSE_ADDR_W-1:`FUSE_WORD_IDX_W]];

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      for (int i = 0; i < `FUSE_WORD_NUM; i++) begin
        mem_q[i] <= '0;
      end
    end else if (prog_fire && !prog_locked) begin
      mem_q[prog_addr_i].raw <= prog_data_i;
    end
  end

  // Ready comes up right after reset, refused writes flag an error a cycle later
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      prog_ready_o <= 1'b0;
      prog_err_o   <= 1'b0;
    end else begin
      prog_ready_o <= 1'b1;
      prog_err_o   <= prog_fire & prog_locked;
    end
  end

  assign scan_word_o = fault_overlay(mem_q[scan_addr_i], scan_addr_i, locked, fault_mode_i);
  assign lc_word     = fault_overlay(mem_q[lc_addr], lc_addr, locked, fault_mode_i);
  assign lc_word_o   = lc_word.half.data;

endmodule

`default_nettype wire

/* verilog/otp_partition_check.sv */
// Continuous round-robin scan of the fuse array that classifies soft and hard errors per partition
`timescale 1ns/1ps
`default_nettype none

`include "fuse_lc_cfg.svh"

module otp_partition_check (
  input  wire logic                    clk,
  input  wire logic                    local_rst_b,
  output logic [`FUSE_ADDR_W-1:0]      scan_addr_o,
  input  wire fuse_lc_pkg::fuse_word_u scan_word_i,
  output logic [`FUSE_PART_NUM-1:0]    soft_err_o,
  output logic [`FUSE_PART_NUM-1:0]    hard_err_o,
  output logic                         scan_done_o
);

  localparam logic [`FUSE_ADDR_W-1:0] last_addr = `FUSE_ADDR_W'(`FUSE_WORD_NUM - 1);

  logic [`FUSE_ADDR_W-1:0]   scan_addr_q;
  logic [`FUSE_PART_NUM-1:0] soft_acc_q;
  logic [`FUSE_PART_NUM-1:0] hard_acc_q;
  logic [`FUSE_PART_NUM-1:0] part_mask;
  logic [`FUSE_PART_NUM-1:0] soft_next;
  logic [`FUSE_PART_NUM-1:0] hard_next;
  logic [4:0]                diff_cnt;
  logic                      pass_end;

  assign scan_addr_o = scan_addr_q;
  assign pass_end    = scan_addr_q == last_addr;

  // Count how many bits of the data half disagree with the mirror
  assign diff_cnt  = 5'($countones(scan_word_i.half.data ^ scan_word_i.half.mirror));
  assign part_mask = {{(`FUSE_PART_NUM-1){1'b0}}, 1'b1} <<
                     scan_addr_q[`FUSE_ADDR_W-1:`FUSE_WORD_IDX_W];

  // One flipped bit is soft, anything more is hard
  assign soft_next = soft_acc_q | ((diff_cnt == 5'd1) ? part_mask : '0);
  assign hard_next = hard_acc_q | ((diff_cnt > 5'd1) ? part_mask : '0);

  always_ff @(posedge clk or negedge local_rst_b) begin
    if (!local_rst_b) begin
      scan_addr_q <= '0;
      soft_acc_q  <= '0;
      hard_acc_q  <= '0;
      soft_err_o  <= '0;
      hard_err_o  <= '0;
      scan_done_o <= 1'b0;
    end else begin
      scan_addr_q <= scan_addr_q + `FUSE_ADDR_W'(1);
      scan_done_o <= pass_end;
      if (pass_end) begin
        // Publish the finished pass and start the next one clean
        soft_err_o <= soft_next;
        hard_err_o <= hard_next;
        soft_acc_q <= '0;
        hard_acc_q <= '0;
      end else begin
        soft_acc_q <= soft_next;
        hard_acc_q <= hard_next;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/lc_state_ctrl.sv */
// Lifecycle state decode with escalation to scrap and zeroization gating
`timescale 1ns/1ps
`default_nettype none

module lc_state_ctrl (
  input  wire logic             clk,
  input  wire logic             local_rst_b,
  input  wire logic [15:0]      lc_word_i,
  input  wire logic             lc_hard_err_i,
  input  wire logic             escalate_i,
  input  wire logic             zeroize_req_i,
  output fuse_lc_pkg::lc_state_e lc_state_o,
  output logic                  zeroize_o
);

  fuse_lc_pkg::lc_state_e state_d;
  logic                   zeroize_ok;

  // ----------------------------------------
  // State decode
  // ----------------------------------------
  always_comb begin
    case (lc_word_i)
      16'd0:   state_d = fuse_lc_pkg::LC_RAW;
      16'd1:   state_d = fuse_lc_pkg::LC_TEST;
      16'd2:   state_d = fuse_lc_pkg::LC_DEV;
      16'd3:   state_d = fuse_lc_pkg::LC_PROD;
      // Any unexpected encoding is treated as a scrapped part
      default: state_d = fuse_lc_pkg::LC_SCRAP;
    endcase

    // Escalation and an uncorrectable lifecycle partition both win over the fuse value
    if (escalate_i || lc_hard_err_i) begin
      state_d = fuse_lc_pkg::LC_SCRAP;
    end
  end

  // Zeroization is only honoured in the mission states
  assign zeroize_ok = (state_d == fuse_lc_pkg::LC_DEV) ||
                      (state_d == fuse_lc_pkg::LC_PROD);

  // ----------------------------------------
  // Registered outputs
  // ----------------------------------------
  always_ff @(posedge clk or negedge local_rst_b) begin
    if (!local_rst_b) begin
      lc_state_o <= fuse_lc_pkg::LC_RAW;
      zeroize_o  <= 1'b0;
    end else begin
      lc_state_o <= state_d;
      zeroize_o  <= zeroize_req_i & zeroize_ok;
    end
  end

endmodule

`default_nettype wire

/* verilog/fuse_lc_top.sv */
// Top level of the fuse and lifecycle subsystem joining the service block, array, checker and LC logic
`timescale 1ns/1ps
`default_nettype none

`include "fuse_lc_cfg.svh"

module fuse_lc_top (
  input  wire logic                    clk,
  input  wire logic                    cptra_rst_b,
  input  wire logic                    cmd_valid_i,
  input  wire fuse_lc_pkg::svc_cmd_e   cmd_i,
  output logic                         cmd_ready_o,
  input  wire logic                    prog_valid_i,
  input  wire logic [`FUSE_ADDR_W-1:0] prog_addr_i,
  input  wire logic [31:0]             prog_data_i,
  output logic                         prog_ready_o,
  output logic                         prog_err_o,
  input  wire logic                    clk_byp_ack_i,
  output fuse_lc_pkg::clk_sel_e        clk_sel_o,
  output logic                         clk_byp_req_o,
  output logic [`FUSE_PART_NUM-1:0]    soft_err_o,
  output logic [`FUSE_PART_NUM-1:0]    hard_err_o,
  output logic                         scan_done_o,
  output fuse_lc_pkg::lc_state_e       lc_state_o,
  output logic                         zeroize_o
);

  localparam int lc_part = `LC_WORD_ADDR / `FUSE_PART_WORDS;

  fuse_lc_pkg::fault_mode_e fault_mode;
  fuse_lc_pkg::fuse_word_u  scan_word;
  logic [`FUSE_ADDR_W-1:0]  scan_addr;
  logic [15:0]              lc_word;
  logic                     escalate;
  logic                     zeroize_req;
  logic                     svc_rst;
  logic                     svc_rst_q;
  logic                     local_rst_b;

  // Local reset follows the service pulse by one flop and also tracks the main reset
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      svc_rst_q <= 1'b0;
    end else begin
      svc_rst_q <= svc_rst;
    end
  end

  assign local_rst_b = cptra_rst_b & ~svc_rst_q;

  fuse_svc_ctrl i_fuse_svc_ctrl (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .cmd_ready_o   (cmd_ready_o),
    .clk_byp_ack_i (clk_byp_ack_i),
    .fault_mode_o  (fault_mode),
    .escalate_o    (escalate),
    .zeroize_req_o (zeroize_req),
    .svc_rst_o     (svc_rst),
    .clk_sel_o     (clk_sel_o),
    .clk_byp_req_o (clk_byp_req_o)
  );

  otp_fuse_array i_otp_fuse_array (
    .clk          (clk),
    .cptra_rst_b  (cptra_rst_b),
    .prog_valid_i (prog_valid_i),
    .prog_addr_i  (prog_addr_i),
    .prog_data_i  (prog_data_i),
    .prog_ready_o (prog_ready_o),
    .prog_err_o   (prog_err_o),
    .fault_mode_i (fault_mode),
    .scan_addr_i  (scan_addr),
    .scan_word_o  (scan_word),
    .lc_word_o    (lc_word)
  );

  otp_partition_check i_otp_partition_check (
    .clk         (clk),
    .local_rst_b (local_rst_b),
    .scan_addr_o (scan_addr),
    .scan_word_i (scan_word),
    .soft_err_o  (soft_err_o),
    .hard_err_o  (hard_err_o),
    .scan_done_o (scan_done_o)
  );

  lc_state_ctrl i_lc_state_ctrl (
    .clk           (clk),
    .local_rst_b   (local_rst_b),
    .lc_word_i     (lc_word),
    .lc_hard_err_i (hard_err_o[lc_part]),
    .escalate_i    (escalate),
    .zeroize_req_i (zeroize_req),
    .lc_state_o    (lc_state_o),
    .zeroize_o     (zeroize_o)
  );

endmodule

`default_nettype wire

/* testbench/fuse_lc_tb.sv */
// Self-checking testbench for the fuse and lifecycle subsystem, compiled from sim.f at the root
`timescale 1ns/1ps
`default_nettype none

`include "fuse_lc_cfg.svh"

module fuse_lc_tb;

  // About 13 scan passes of 64 cycles plus 66 programmed words, with a wide margin
  localparam int max_cycles = 3000;
  localparam int lc_part    = `LC_WORD_ADDR / `FUSE_PART_WORDS;

  logic                       clk;
  logic                       cptra_rst_b;
  logic                       cmd_valid_i;
  fuse_lc_pkg::svc_cmd_e      cmd_i;
  logic                       cmd_ready_o;
  logic                       prog_valid_i;
  logic [`FUSE_ADDR_W-1:0]    prog_addr_i;
  logic [31:0]                prog_data_i;
  logic                       prog_ready_o;
  logic                       prog_err_o;
  logic                       clk_byp_ack_i;
  fuse_lc_pkg::clk_sel_e      clk_sel_o;
  logic                       clk_byp_req_o;
  logic [`FUSE_PART_NUM-1:0]  soft_err_o;
  logic [`FUSE_PART_NUM-1:0]  hard_err_o;
  logic                       scan_done_o;
  fuse_lc_pkg::lc_state_e     lc_state_o;
  logic                       zeroize_o;

  int                         cycle_cnt = 0;
  int                         check_cnt = 0;
  int                         err_cnt = 0;
  int                         test_num = 0;
  int                         tests_ok = 0;
  int                         test_err_base = 0;
  int                         rst_cycles;
  logic [31:0]                rnd;
  logic [`FUSE_PART_NUM-1:0]  locked_mask;
  fuse_lc_pkg::lc_state_e     exp_lc;

  fuse_lc_top i_fuse_lc_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // A stuck handshake or a missing scan pulse ends the run here
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout after %0d cycles, a handshake or scan pulse never arrived", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] mirrored_word(input logic [15:0] d);
    return {d, d};
  endfunction

  task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", sig, got, exp);
      err_cnt++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Returns on the falling edge where the pass result is visible
  task automatic wait_scan_done();
    @(negedge clk);
    while (!scan_done_o) begin
      @(negedge clk);
    end
  endtask

  task automatic program_word(input int addr, input logic [31:0] data, input logic exp_err);
    @(posedge clk);
    prog_valid_i <= 1'b1;
    prog_addr_i  <= addr[`FUSE_ADDR_W-1:0];
    prog_data_i  <= data;
    @(negedge clk);
    while (!prog_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    prog_valid_i <= 1'b0;
    @(negedge clk);
    check_val("prog_err_o", 32'(prog_err_o), 32'(exp_err));
  endtask

  // Returns on the rising edge that accepts the command
  task automatic send_cmd(input fuse_lc_pkg::svc_cmd_e cmd);
    @(posedge clk);
    cmd_valid_i <= 1'b1;
    cmd_i       <= cmd;
    @(negedge clk);
    while (!cmd_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    cmd_valid_i <= 1'b0;
  endtask

  task automatic clk_switch(input fuse_lc_pkg::svc_cmd_e cmd, input fuse_lc_pkg::clk_sel_e sel);
    send_cmd(cmd);
    wait_cycles(1);
    check_val("clk_sel_o", 32'(clk_sel_o), 32'(sel));
    check_val("clk_byp_req_o", 32'(clk_byp_req_o), 32'h1);
    repeat ($urandom_range(1, 4)) begin
      check_val("cmd_ready_o", 32'(cmd_ready_o), 32'h0);
      @(negedge clk);
    end
    @(posedge clk);
    clk_byp_ack_i <= 1'b1;
    @(negedge clk);
    while (clk_byp_req_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    clk_byp_ack_i <= 1'b0;
    @(negedge clk);
    check_val("cmd_ready_o", 32'(cmd_ready_o), 32'h1);
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (err_cnt == test_err_base) begin
      tests_ok++;
      $display("test %0d %s: passed", test_num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", test_num, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    void'($urandom(32'h5121_2423));
    cptra_rst_b   <= 1'b0;
    cmd_valid_i   <= 1'b0;
    cmd_i         <= fuse_lc_pkg::CMD_FAULT_RELEASE;
    prog_valid_i  <= 1'b0;
    prog_addr_i   <= '0;
    prog_data_i   <= '0;
    clk_byp_ack_i <= 1'b0;
    repeat (3) @(posedge clk);
    cptra_rst_b <= 1'b1;

    // Idle values once the first clock after reset has passed
    wait_cycles(2);
    check_val("prog_ready_o", 32'(prog_ready_o), 32'h1);
    check_val("cmd_ready_o", 32'(cmd_ready_o), 32'h1);
    check_val("clk_sel_o", 32'(clk_sel_o), 32'(fuse_lc_pkg::CLK_SEL_1000));
    check_val("clk_byp_req_o", 32'(clk_byp_req_o), 32'h0);
    check_val("prog_err_o", 32'(prog_err_o), 32'h0);
    check_val("zeroize_o", 32'(zeroize_o), 32'h0);
    check_val("scan_done_o", 32'(scan_done_o), 32'h0);
    check_val("soft_err_o", 32'(soft_err_o), 32'h0);
    check_val("hard_err_o", 32'(hard_err_o), 32'h0);

    // Data words first, the digest last since a nonzero digest locks the partition
    locked_mask = '0;
    for (int p = 0; p < `FUSE_PART_NUM; p++) begin
      for (int w = 0; w < `FUSE_PART_WORDS - 1; w++) begin
        rnd = $urandom;
        if (p * `FUSE_PART_WORDS + w == `LC_WORD_ADDR) begin
          program_word(`LC_WORD_ADDR, mirrored_word(16'd3), 1'b0);
        end else begin
          program_word(p * `FUSE_PART_WORDS + w, mirrored_word(rnd[15:0]), 1'b0);
        end
      end
      rnd = $urandom;
      locked_mask[p] = (p % 2 == 0);
      program_word(p * `FUSE_PART_WORDS + `FUSE_PART_WORDS - 1,
                   locked_mask[p] ? mirrored_word(rnd[15:0] | 16'h1) : 32'h0, 1'b0);
    end
    // The refused word carries a broken mirror so that a write getting through shows in the scan
    program_word(1, 32'h1234_5678, 1'b1);
    program_word(`FUSE_PART_WORDS + 1, mirrored_word(16'h5678), 1'b0);
    wait_scan_done();
    wait_scan_done();
    check_val("soft_err_o", 32'(soft_err_o), 32'h0);
    check_val("hard_err_o", 32'(hard_err_o), 32'h0);
    check_val("lc_state_o", 32'(lc_state_o), 32'(fuse_lc_pkg::LC_PROD));
    end_test("program and lock");

    send_cmd(fuse_lc_pkg::CMD_FAULT_SOFT);
    wait_scan_done();
    wait_scan_done();
    check_val("soft_err_o", 32'(soft_err_o), 32'(locked_mask));
    check_val("hard_err_o", 32'(hard_err_o), 32'h0);
    send_cmd(fuse_lc_pkg::CMD_FAULT_RELEASE);
    wait_scan_done();
    wait_scan_done();
    check_val("soft_err_o", 32'(soft_err_o), 32'h0);
    check_val("hard_err_o", 32'(hard_err_o), 32'h0);
    end_test("soft fault");

    send_cmd(fuse_lc_pkg::CMD_FAULT_HARD);
    wait_scan_done();
    wait_scan_done();
    wait_cycles(1);
    exp_lc = locked_mask[lc_part] ? fuse_lc_pkg::LC_SCRAP : fuse_lc_pkg::LC_PROD;
    check_val("hard_err_o", 32'(hard_err_o), 32'(locked_mask));
    check_val("soft_err_o", 32'(soft_err_o), 32'h0);
    check_val("lc_state_o", 32'(lc_state_o), 32'(exp_lc));
    send_cmd(fuse_lc_pkg::CMD_FAULT_RELEASE);
    // The lifecycle word reads PROD again but the published hard error still forces SCRAP
    wait_cycles(2);
    check_val("lc_state_o", 32'(lc_state_o), 32'(exp_lc));
    wait_scan_done();
    wait_scan_done();
    wait_cycles(1);
    check_val("hard_err_o", 32'(hard_err_o), 32'h0);
    check_val("lc_state_o", 32'(lc_state_o), 32'(fuse_lc_pkg::LC_PROD));
    end_test("hard fault");

    send_cmd(fuse_lc_pkg::CMD_ZEROIZE);
    wait_cycles(2);
    check_val("zeroize_o", 32'(zeroize_o), 32'h1);
    send_cmd(fuse_lc_pkg::CMD_ESCALATE);
    wait_cycles(2);
    check_val("lc_state_o", 32'(lc_state_o), 32'(fuse_lc_pkg::LC_SCRAP));
    check_val("zeroize_o", 32'(zeroize_o), 32'h0);
    send_cmd(fuse_lc_pkg::CMD_ESCALATE_RELEASE);
    wait_cycles(2);
    check_val("lc_state_o", 32'(lc_state_o), 32'(fuse_lc_pkg::LC_PROD));
    check_val("zeroize_o", 32'(zeroize_o), 32'h1);
    send_cmd(fuse_lc_pkg::CMD_ZEROIZE_RELEASE);
    wait_cycles(2);
    check_val("zeroize_o", 32'(zeroize_o), 32'h0);
    end_test("escalate and zeroize");

    clk_switch(fuse_lc_pkg::CMD_CLK_160, fuse_lc_pkg::CLK_SEL_160);
    clk_switch(fuse_lc_pkg::CMD_CLK_400, fuse_lc_pkg::CLK_SEL_400);
    clk_switch(fuse_lc_pkg::CMD_CLK_500, fuse_lc_pkg::CLK_SEL_500);
    clk_switch(fuse_lc_pkg::CMD_CLK_1000, fuse_lc_pkg::CLK_SEL_1000);
    end_test("clock handshake");

    // A soft fault flips bit 0 of a locked lifecycle word so PROD reads as DEV
    send_cmd(fuse_lc_pkg::CMD_FAULT_SOFT);
    wait_scan_done();
    wait_scan_done();
    check_val("soft_err_o", 32'(soft_err_o), 32'(locked_mask));
    send_cmd(fuse_lc_pkg::CMD_LOCAL_RESET);
    rst_cycles = 0;
    @(negedge clk);
    while (!cmd_ready_o) begin
      rst_cycles++;
      @(negedge clk);
    end
    check_val("cmd_ready_o low cycles", 32'(rst_cycles), 32'(`SVC_RST_CYCLES));
    while (!scan_done_o) begin
      check_val("soft_err_o", 32'(soft_err_o), 32'h0);
      check_val("hard_err_o", 32'(hard_err_o), 32'h0);
      @(negedge clk);
    end
    exp_lc = locked_mask[lc_part] ? fuse_lc_pkg::LC_DEV : fuse_lc_pkg::LC_PROD;
    check_val("soft_err_o", 32'(soft_err_o), 32'(locked_mask));
    check_val("lc_state_o", 32'(lc_state_o), 32'(exp_lc));
    send_cmd(fuse_lc_pkg::CMD_FAULT_RELEASE);
    wait_cycles(2);
    check_val("lc_state_o", 32'(lc_state_o), 32'(fuse_lc_pkg::LC_PROD));
    end_test("local reset");

    $display("%0d of %0d tests passed, %0d checks, %0d errors",
             tests_ok, test_num, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verilog
verilog/fuse_lc_pkg.sv
verilog/fuse_svc_ctrl.sv
verilog/otp_fuse_array.sv
verilog/otp_partition_check.sv
verilog/lc_state_ctrl.sv
verilog/fuse_lc_top.sv
testbench/fuse_lc_tb.sv

/* Makefile */
TOP := fuse_lc_tb
SRCS := sim.f $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module fuse_lc_top

clean:
	rm -rf obj_dir
